/* line_pkg.sv */
// shared widths and beat count for the cache-line read path; imported by every rtl module.
package line_pkg;

    // byte address as seen by the clients and the memory port.
    localparam int addr_w = 32;

    // one external memory word.
    localparam int word_w = 32;

    // one cache line, four words wide.
    localparam int line_w = 128;

    // words per line.
    localparam int line_beats = 4;

    // enough bits to count line_beats words.
    localparam int beat_cnt_w = 2;

    // low address bits that select a byte inside a line.
    localparam int line_offset_w = 4;

endpackage

/* link_readline.sv */
// request-holding slice between one readline client and the arbiter; one per client.
`timescale 1ns/10ps

module link_readline
    import line_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // client side.
    input  logic              req_readline_do,
    output logic              req_readline_done,
    input  logic [addr_w-1:0] req_readline_address,
    output logic [line_w-1:0] req_readline_line,

    // arbiter side.
    output logic              resp_readline_do,
    input  logic              resp_readline_done,
    output logic [addr_w-1:0] resp_readline_address,
    input  logic [line_w-1:0] resp_readline_line
);

    logic              pending;       // request seen, answer not yet back.
    logic [addr_w-1:0] saved_address; // address of the pending request.
    logic              save;          // capture strobe.

    // a do in the same cycle as done belongs to the old request.
    assign save = req_readline_do && !resp_readline_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (save) begin
            pending <= 1'b1;                // hold until answered.
        end else if (resp_readline_done) begin
            pending <= 1'b0;                // answer delivered.
        end
    end

    always_ff @(posedge clk) begin
        if (save) begin
            saved_address <= req_readline_address; // keep for a short do.
        end
    end

    // live request wins, saved one covers a dropped do.
    assign resp_readline_do      = req_readline_do || pending;
    assign resp_readline_address = req_readline_do ? req_readline_address : saved_address;

    // answer goes straight back to the client.
    assign req_readline_done = resp_readline_done;
    assign req_readline_line = resp_readline_line;

endmodule

/* readline_arbiter.sv */
// fixed-priority arbiter between code and data readline links; grant held until the line is done.
`timescale 1ns/10ps

module readline_arbiter
    import line_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // code fetch link.
    input  logic              code_do,
    input  logic [addr_w-1:0] code_address,
    output logic              code_done,

    // data link.
    input  logic              data_do,
    input  logic [addr_w-1:0] data_address,
    output logic              data_done,

    // burst reader side.
    output logic              line_do,
    output logic [addr_w-1:0] line_address,
    input  logic              line_done
);

    logic busy;       // a line transaction is owned.
    logic owner_data; // owner of the transaction, 1 for data.
    logic pick_data;  // choice made while idle.
    logic cur_data;   // owner in effect this cycle.

    // data beats code when both ask together.
    assign pick_data = data_do;

    // while idle the choice is live, while busy it is locked.
    assign cur_data = busy ? owner_data : pick_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
        end else if (line_done) begin
            busy <= 1'b0;                   // release on the forwarded done.
        end else if (!busy && (code_do || data_do)) begin
            busy       <= 1'b1;             // lock grant at the next edge.
            owner_data <= pick_data;
        end
    end

    // Links keep do up until their done arrives, so the owner's do stays high
    // for the whole transaction and the loser waits with its do held.
    assign line_do      = cur_data ? data_do : code_do;
    assign line_address = cur_data ? data_address : code_address;

    // done goes only to the owner.
    assign data_done = line_done && cur_data;
    assign code_done = line_done && !cur_data;

endmodule

/* line_burst_reader.sv */
// burst reader that fetches one cache line as word reads on a pipelined memory port.
`timescale 1ns/10ps

module line_burst_reader
    import line_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // line request from the arbiter.
    input  logic              line_do,
    input  logic [addr_w-1:0] line_address,
    output logic              line_done,
    output logic [line_w-1:0] line_data,

    // pipelined memory port.
    output logic              mem_read,
    output logic [addr_w-1:0] mem_address,
    input  logic              mem_waitrequest,
    input  logic [word_w-1:0] mem_readdata,
    input  logic              mem_readdatavalid
);

    logic                            active;     // request latched, line not complete.
    logic [addr_w-line_offset_w-1:0] base_hi;    // line base without offset bits.
    logic [beat_cnt_w-1:0]           issue_cnt;  // word being requested.
    logic [beat_cnt_w-1:0]           ret_cnt;    // slot for the next returned word.
    logic                            start;      // new request accepted.
    logic                            accept;     // memory takes the current read.
    logic                            last_issue; // final word on the bus.
    logic                            beat_in;    // word returning for this line.
    logic                            last_ret;   // final word slot.

    // done cycle still sees the old do, so it cannot restart.
    assign start = !active && line_do && !line_done;

    assign accept     = mem_read && !mem_waitrequest;
    assign last_issue = (issue_cnt == beat_cnt_w'(line_beats - 1));
    assign beat_in    = active && mem_readdatavalid;
    assign last_ret   = (ret_cnt == beat_cnt_w'(line_beats - 1));

    // word-aligned address inside the latched line.
    assign mem_address = {base_hi, issue_cnt, {(line_offset_w - beat_cnt_w){1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            mem_read  <= 1'b0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= beat_in && last_ret;   // one cycle after the last word.
            if (start) begin
                active    <= 1'b1;
                mem_read  <= 1'b1;              // first read next cycle.
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                // waitrequest freezes the issue side only.
                if (accept) begin
                    if (last_issue) begin
                        mem_read <= 1'b0;       // all words requested.
                    end else begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                end
                // returns keep counting through any stall.
                if (beat_in) begin
                    ret_cnt <= ret_cnt + 1'b1;
                    if (last_ret) begin
                        active <= 1'b0;         // line complete.
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_hi <= line_address[addr_w-1:line_offset_w]; // drop offset bits.
        end
        if (beat_in) begin
            line_data[ret_cnt*word_w +: word_w] <= mem_readdata; // word 0 lowest.
        end
    end

endmodule

/* readline_top.sv */
// top level of the line read path; two client links share one burst reader through an arbiter.
`timescale 1ns/10ps

module readline_top
    import line_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // code fetch client.
    input  logic              code_readline_do,
    input  logic [addr_w-1:0] code_readline_address,
    output logic              code_readline_done,
    output logic [line_w-1:0] code_readline_line,

    // data client.
    input  logic              data_readline_do,
    input  logic [addr_w-1:0] data_readline_address,
    output logic              data_readline_done,
    output logic [line_w-1:0] data_readline_line,

    // external memory.
    output logic              mem_read,
    output logic [addr_w-1:0] mem_address,
    input  logic              mem_waitrequest,
    input  logic [word_w-1:0] mem_readdata,
    input  logic              mem_readdatavalid
);

    logic              code_arb_do;      // held code request.
    logic [addr_w-1:0] code_arb_address;
    logic              code_arb_done;
    logic              data_arb_do;      // held data request.
    logic [addr_w-1:0] data_arb_address;
    logic              data_arb_done;
    logic              rd_do;            // granted request.
    logic [addr_w-1:0] rd_address;
    logic              rd_done;
    logic [line_w-1:0] rd_line;          // shared line, qualified by each done.

    link_readline link_code (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .req_readline_do       (code_readline_do),
        .req_readline_done     (code_readline_done),
        .req_readline_address  (code_readline_address),
        .req_readline_line     (code_readline_line),
        .resp_readline_do      (code_arb_do),
        .resp_readline_done    (code_arb_done),
        .resp_readline_address (code_arb_address),
        .resp_readline_line    (rd_line)
    );

    link_readline link_data (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .req_readline_do       (data_readline_do),
        .req_readline_done     (data_readline_done),
        .req_readline_address  (data_readline_address),
        .req_readline_line     (data_readline_line),
        .resp_readline_do      (data_arb_do),
        .resp_readline_done    (data_arb_done),
        .resp_readline_address (data_arb_address),
        .resp_readline_line    (rd_line)
    );

    readline_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .code_do      (code_arb_do),
        .code_address (code_arb_address),
        .code_done    (code_arb_done),
        .data_do      (data_arb_do),
        .data_address (data_arb_address),
        .data_done    (data_arb_done),
        .line_do      (rd_do),
        .line_address (rd_address),
        .line_done    (rd_done)
    );

    line_burst_reader u_reader (
        .clk               (clk),
        .rst_n             (rst_n),
        .line_do           (rd_do),
        .line_address      (rd_address),
        .line_done         (rd_done),
        .line_data         (rd_line),
        .mem_read          (mem_read),
        .mem_address       (mem_address),
        .mem_waitrequest   (mem_waitrequest),
        .mem_readdata      (mem_readdata),
        .mem_readdatavalid (mem_readdatavalid)
    );

endmodule

/* tb_clock_gen.sv */
// testbench clock and reset source; 20 ns clock, reset held low for the first 4 rising edges.
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 10; // ns, gives a 20 ns clock.
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                       // in reset from time zero.
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;                      // release on a rising edge.
    end

endmodule

/* readline_mem_model.sv */
// testbench memory with a pipelined read port, random waitrequest and random in-order latency.
`timescale 1ns/10ps

module readline_mem_model
    import line_pkg::*;
#(
    parameter logic [word_w-1:0] pattern = 32'h5a5a_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_read,
    input  logic [addr_w-1:0] mem_address,
    output logic              mem_waitrequest,
    output logic [word_w-1:0] mem_readdata,
    output logic              mem_readdatavalid
);

    logic [31:0]       rnd = 32'ha905; // xorshift state.
    logic [word_w-1:0] ret_data[$];    // accepted reads, oldest first.
    int                ret_due[$];     // cycle each read comes back in.
    int                cyc;            // cycles since reset.
    int                last_due;       // keeps returns in order.
    int                due;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_waitrequest   <= 1'b0;
            mem_readdatavalid <= 1'b0;
            mem_readdata      <= '0;
            ret_data.delete();
            ret_due.delete();
            cyc      = 0;
            last_due = 0;
        end else begin
            rnd = xorshift32(rnd);
            if (mem_read && !mem_waitrequest) begin
                due = cyc + 1 + int'(rnd[9:8]);    // 0 to 3 extra cycles.
                if (due <= last_due) begin
                    due = last_due + 1;            // never overtake an older read.
                end
                last_due = due;
                ret_data.push_back(mem_address ^ pattern);
                ret_due.push_back(due);
            end
            if (ret_due.size() > 0 && ret_due[0] <= cyc + 1) begin
                void'(ret_due.pop_front());
                mem_readdatavalid <= 1'b1;
                mem_readdata      <= ret_data.pop_front();
            end else begin
                mem_readdatavalid <= 1'b0;
            end
            mem_waitrequest <= (rnd[1:0] == 2'b00); // stall about one cycle in four.
            cyc = cyc + 1;
        end
    end

endmodule

/* readline_tb.sv */
// testbench for the line read path; drives both clients and checks answers with assertions.
`timescale 1ns/10ps

module readline_tb
    import line_pkg::*;
();

    localparam int                num_requests       = 40;
    localparam int                cycles_per_request = 60;
    localparam int                cycle_limit        = num_requests * cycles_per_request + 100;
    localparam logic [word_w-1:0] pattern            = 32'h5a5a_0000;

    logic              clk;
    logic              rst_n;
    logic              code_readline_do;
    logic [addr_w-1:0] code_readline_address;
    logic              code_readline_done;
    logic [line_w-1:0] code_readline_line;
    logic              data_readline_do;
    logic [addr_w-1:0] data_readline_address;
    logic              data_readline_done;
    logic [line_w-1:0] data_readline_line;
    logic              mem_read;
    logic [addr_w-1:0] mem_address;
    logic              mem_waitrequest;
    logic [word_w-1:0] mem_readdata;
    logic              mem_readdatavalid;

    logic [line_w-1:0] exp_line[2];     // index 0 code, 1 data.
    logic [addr_w-1:0] req_addr[2];
    int                req_cnt[2];      // requests issued.
    int                done_cnt[2];     // dones seen.
    logic              paired;          // both clients raised do together.
    logic              stall_q;         // read held off last cycle.
    logic [addr_w-1:0] addr_q;
    logic              rst_n_q;         // low for one cycle after release.
    logic              in_served_line;
    logic [31:0]       rnd = 32'ha905;
    int                cycle_cnt = 0;

    tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    readline_top UUT (.*);

    readline_mem_model #(.pattern(pattern)) u_mem (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // four words of the line holding addr, word 0 in the low bits.
    function automatic logic [line_w-1:0] line_of(input logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        logic [addr_w-1:0] base;
        base = addr & 32'hffff_fff0;
        for (int i = 0; i < 4; i++) begin
            line[i*word_w +: word_w] = (base + 32'(4 * i)) ^ pattern;
        end
        return line;
    endfunction

    task automatic end_in_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [line_w-1:0] expected,
                                  input logic [line_w-1:0] actual);
        $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end_in_failure();
    endtask

    task automatic flag_problem(input string what);
        $display("error at %0t ns: %s", $time, what);
        end_in_failure();
    endtask

    task automatic release_do(input int c);
        if (c == 0) begin
            code_readline_do <= 1'b0;
        end else begin
            data_readline_do <= 1'b0;
        end
    endtask

    // one request from one client, from raising do to seeing done.
    task automatic run_client(input int c, input logic [addr_w-1:0] addr,
                              input bit short_do, input int lead);
        repeat (lead) @(posedge clk);
        if (c == 0) begin
            code_readline_do      <= 1'b1;
            code_readline_address <= addr;
        end else begin
            data_readline_do      <= 1'b1;
            data_readline_address <= addr;
        end
        req_addr[c] <= addr;
        exp_line[c] <= line_of(addr);
        req_cnt[c]  <= req_cnt[c] + 1;
        if (short_do) begin
            @(posedge clk);
            release_do(c);                   // single-cycle do.
        end
        do @(negedge clk); while (!(c == 0 ? code_readline_done : data_readline_done));
        @(posedge clk);
        release_do(c);
    endtask

    // mode 0 code only, 1 data only, 2 same-cycle pair, 3 data lags code.
    task automatic run_round(input int mode, input logic [addr_w-1:0] code_a,
                             input logic [addr_w-1:0] data_a, input bit code_short,
                             input bit data_short, input int lag);
        @(posedge clk);
        case (mode)
            0: run_client(0, code_a, code_short, 0);
            1: run_client(1, data_a, data_short, 0);
            2: begin
                paired <= 1'b1;
                fork
                    run_client(0, code_a, code_short, 0);
                    run_client(1, data_a, data_short, 0);
                join
                paired <= 1'b0;
            end
            default: begin
                fork
                    run_client(0, code_a, code_short, 0);
                    run_client(1, data_a, data_short, lag);
                join
            end
        endcase
    endtask

    initial begin
        int               total;
        int               mode;
        logic [addr_w-1:0] a0;
        logic [addr_w-1:0] a1;
        code_readline_do      = 1'b0;
        code_readline_address = '0;
        data_readline_do      = 1'b0;
        data_readline_address = '0;
        paired                = 1'b0;
        req_cnt[0]            = 0;
        req_cnt[1]            = 0;
        @(posedge rst_n);
        run_round(0, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 0);       // aligned, do held.
        run_round(1, 32'h0, 32'h0000_2a37, 1'b1, 1'b1, 0);       // offset, short do.
        run_round(2, 32'h0001_0004, 32'h0002_000c, 1'b1, 1'b0, 0);
        total = 4;
        while (total < num_requests) begin
            rnd  = xorshift32(rnd);
            mode = int'(rnd[1:0]);
            if (mode >= 2 && total == num_requests - 1) begin
                mode = 0;                    // room for one request only.
            end
            a0  = xorshift32(rnd);
            a1  = xorshift32(a0);
            rnd = xorshift32(a1);
            run_round(mode, a0, a1, rnd[4], rnd[5], 2 + int'(rnd[7:6]));
            total = total + ((mode >= 2) ? 2 : 1);
        end
        repeat (5) @(posedge clk);
        if (req_cnt[0] == done_cnt[0] && req_cnt[1] == done_cnt[1] &&
            req_cnt[0] + req_cnt[1] == num_requests) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            flag_problem("request and done counts differ at the end of the run");
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_cnt[0] <= 0;
            done_cnt[1] <= 0;
            stall_q     <= 1'b0;
            addr_q      <= '0;
            rst_n_q     <= 1'b0;
        end else begin
            if (code_readline_done) begin
                done_cnt[0] <= done_cnt[0] + 1;
            end
            if (data_readline_done) begin
                done_cnt[1] <= done_cnt[1] + 1;
            end
            stall_q <= mem_read && mem_waitrequest; // read offered but held off.
            addr_q  <= mem_address;
            rst_n_q <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            flag_problem("timeout, the requests did not all finish in time");
        end
    end

    // address must fall in the line of some outstanding request.
    assign in_served_line =
        (req_cnt[0] != done_cnt[0] &&
         mem_address[addr_w-1:line_offset_w] == req_addr[0][addr_w-1:line_offset_w]) ||
        (req_cnt[1] != done_cnt[1] &&
         mem_address[addr_w-1:line_offset_w] == req_addr[1][addr_w-1:line_offset_w]);

    assert property (@(posedge clk) disable iff (!rst_n)
        code_readline_done |-> code_readline_line == exp_line[0])
        else value_mismatch("code_readline_line", $sampled(exp_line[0]),
                            $sampled(code_readline_line));
    assert property (@(posedge clk) disable iff (!rst_n)
        data_readline_done |-> data_readline_line == exp_line[1])
        else value_mismatch("data_readline_line", $sampled(exp_line[1]),
                            $sampled(data_readline_line));
    assert property (@(posedge clk) disable iff (!rst_n)
        code_readline_done |-> req_cnt[0] != done_cnt[0])
        else flag_problem("code_readline_done with no code request outstanding");
    assert property (@(posedge clk) disable iff (!rst_n)
        data_readline_done |-> req_cnt[1] != done_cnt[1])
        else flag_problem("data_readline_done with no data request outstanding");
    assert property (@(posedge clk) disable iff (!rst_n)
        !(code_readline_done && data_readline_done))
        else flag_problem("code and data done high in the same cycle");
    assert property (@(posedge clk) disable iff (!rst_n)
        (paired && code_readline_done) |-> done_cnt[1] == req_cnt[1])
        else flag_problem("code answered before data after a same-cycle request");
    assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> mem_read)
        else value_mismatch("mem_read", 1, $sampled(mem_read));
    assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> mem_address == addr_q)
        else value_mismatch("mem_address", $sampled(addr_q), $sampled(mem_address));
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_read |-> mem_address[1:0] == 2'b00)
        else value_mismatch("mem_address[1:0]", 0, $sampled(mem_address[1:0]));
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_read |-> in_served_line)
        else flag_problem("mem_address outside the line of every outstanding request");
    assert property (@(posedge clk) disable iff (!rst_n)
        (req_cnt[0] == done_cnt[0] && req_cnt[1] == done_cnt[1]) |-> !mem_read)
        else flag_problem("mem_read high with no request outstanding");

    // reset checks run while rst_n is low too.
    assert property (@(posedge clk) !rst_n_q |-> !mem_read)
        else value_mismatch("mem_read", 0, $sampled(mem_read));
    assert property (@(posedge clk) !rst_n_q |-> !code_readline_done)
        else value_mismatch("code_readline_done", 0, $sampled(code_readline_done));
    assert property (@(posedge clk) !rst_n_q |-> !data_readline_done)
        else value_mismatch("data_readline_done", 0, $sampled(data_readline_done));

endmodule

/* compile.f */
line_pkg.sv
link_readline.sv
readline_arbiter.sv
line_burst_reader.sv
readline_top.sv
tb_clock_gen.sv
readline_mem_model.sv
readline_tb.sv

/* run.sh */
#!/bin/sh
# Builds the readline testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module readline_tb -o Vreadline_tb

# tee keeps the pipeline status at zero so the log search decides the result.
./obj_dir/Vreadline_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

echo "simulation passed"
